// ==== tb.f ====
logic/mem_maint_pkg.sv
logic/maint_sequencer.sv
logic/zero_filler.sv
logic/image_loader.sv
logic/readback_verifier.sv
logic/mem_port_mux.sv
logic/mem_maint_top.sv
verification/tb_dram_model.sv
verification/tb_mem_maint.sv

// ==== Bender.yml ====
package:
  name: mem_maint

sources:
  - logic/mem_maint_pkg.sv
  - logic/maint_sequencer.sv
  - logic/zero_filler.sv
  - logic/image_loader.sv
  - logic/readback_verifier.sv
  - logic/mem_port_mux.sv
  - logic/mem_maint_top.sv
  - target: test
    files:
      - verification/tb_dram_model.sv
      - verification/tb_mem_maint.sv

// ==== verification/tb_mem_maint.sv ====
// testbench for the memory maintenance block
// zero fill, image load, readback verify, user traffic and a corrupted
// readback, all against a behavioral DRAM controller
`timescale 1ns/1ps

module tb_mem_maint;
    import mem_maint_pkg::*;

    localparam int unsigned MEM_SIZE       = 256;
    localparam int unsigned IMAGE_SIZE     = 128;
    localparam int unsigned USER_ADDR_BITS = 26;
    localparam int unsigned MEM_WORDS      = MEM_SIZE / 4;
    localparam int unsigned IMG_WORDS      = IMAGE_SIZE / 4;
    localparam int unsigned N_USER_OPS     = 40;
    // two maintenance passes plus user ops, each op well under 20 cycles
    localparam int unsigned WATCHDOG_CYCLES =
        (2 * (MEM_WORDS + 2 * IMG_WORDS) + N_USER_OPS + 60) * 20;
    localparam logic [31:0] USER_MASK = (32'd1 << USER_ADDR_BITS) - 32'd1;

    logic              clk;
    logic              i_rst, i_calib_done;
    logic              i_img_valid, o_img_ready;
    logic [DATA_W-1:0] i_img_data;
    logic              i_rd_en, i_wr_en, o_busy;
    logic [ADDR_W-1:0] i_addr;
    logic [DATA_W-1:0] i_wdata, o_rdata;
    logic [CTRL_W-1:0] i_ctrl;
    logic              mem_rd_en, mem_wr_en, mem_busy;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata, mem_rdata;
    logic [CTRL_W-1:0] mem_ctrl;
    logic              o_init_done, o_verify_match;
    logic [DATA_W-1:0] o_load_checksum, o_verify_checksum;

    logic [31:0] rand_state = 32'hc473_588b;
    logic [31:0] image [IMG_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    logic [31:0] image_sum;

    mem_maint_top #(
        .MEM_SIZE(MEM_SIZE), .IMAGE_SIZE(IMAGE_SIZE), .USER_ADDR_BITS(USER_ADDR_BITS)
    ) UUT (
        .clk(clk), .i_rst(i_rst), .i_calib_done(i_calib_done),
        .i_img_valid(i_img_valid), .i_img_data(i_img_data), .o_img_ready(o_img_ready),
        .i_rd_en(i_rd_en), .i_wr_en(i_wr_en), .i_addr(i_addr), .i_wdata(i_wdata),
        .i_ctrl(i_ctrl), .o_rdata(o_rdata), .o_busy(o_busy),
        .o_mem_rd_en(mem_rd_en), .o_mem_wr_en(mem_wr_en), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .o_mem_ctrl(mem_ctrl), .i_mem_rdata(mem_rdata),
        .i_mem_busy(mem_busy), .o_init_done(o_init_done),
        .o_load_checksum(o_load_checksum), .o_verify_checksum(o_verify_checksum),
        .o_verify_match(o_verify_match)
    );

    tb_dram_model #(.MEM_SIZE(MEM_SIZE)) u_dram (
        .clk(clk), .i_rst(i_rst), .i_rd_en(mem_rd_en), .i_wr_en(mem_wr_en),
        .i_addr(mem_addr), .i_wdata(mem_wdata), .i_ctrl(mem_ctrl),
        .o_rdata(mem_rdata), .o_busy(mem_busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the DUT did not finish its work within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  be);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b])
                result[8*b +: 8] = new_word[8*b +: 8];
        end
        return result;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        i_rst <= 1'b1;
        repeat (5) @(posedge clk);
        i_rst <= 1'b0;
    endtask

    task automatic wait_log(input int n);
        while (u_dram.log_count < n) @(negedge clk);
    endtask

    task automatic wait_init_done();
        do @(negedge clk); while (!o_init_done);
    endtask

    // new image words, sent with random idle gaps on valid
    task automatic load_image();
        int gap;
        image_sum = '0;
        for (int i = 0; i < IMG_WORDS; i++) begin
            image[i]  = next_rand();
            image_sum = image_sum + image[i];  // mod 2^32
            gap       = int'(next_rand() >> 30);
            repeat (gap) @(posedge clk);
            @(posedge clk);
            i_img_valid <= 1'b1;
            i_img_data  <= image[i];
            do @(negedge clk); while (!o_img_ready);
            @(posedge clk);  // transfer edge
            i_img_valid <= 1'b0;
        end
    endtask

    task automatic user_access(input logic is_write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               output logic [31:0] rdata);
        int first;
        first = u_dram.log_count;
        @(posedge clk);
        i_wr_en <= is_write;
        i_rd_en <= !is_write;
        i_addr  <= addr;
        i_wdata <= wdata;
        i_ctrl  <= be;
        do @(negedge clk); while (!o_busy);
        @(posedge clk);
        i_wr_en <= 1'b0;
        i_rd_en <= 1'b0;
        do @(negedge clk); while (o_busy);
        rdata = o_rdata;
        check_value("user address at controller", u_dram.log_addr[first], addr & USER_MASK);
    endtask

    task automatic test_reset_gate();
        repeat (50) @(posedge clk);
        @(negedge clk);
        check_value("requests before calibration", u_dram.log_count, 0);
        check_value("busy before calibration", o_busy, 1);
        check_value("init done before calibration", o_init_done, 0);
        check_value("image ready before load stage", o_img_ready, 0);
        check_value("load checksum after reset", o_load_checksum, 0);
        check_value("verify checksum after reset", o_verify_checksum, 0);
        check_value("verify match after reset", o_verify_match, 0);
    endtask

    task automatic test_zero_fill();
        @(posedge clk);
        i_calib_done <= 1'b1;
        wait_log(MEM_WORDS);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value("zero fill is a write", u_dram.log_wr[i], 1);
            check_value("zero fill address", u_dram.log_addr[i], 4 * i);
            check_value("zero fill data", u_dram.log_data[i], 0);
            check_value("zero fill byte enables", u_dram.log_ctrl[i], 4'hf);
        end
    endtask

    task automatic test_image_load();
        int n;
        load_image();
        wait_log(MEM_WORDS + IMG_WORDS);
        for (int i = 0; i < IMG_WORDS; i++) begin
            n = MEM_WORDS + i;
            check_value("image write flag", u_dram.log_wr[n], 1);
            check_value("image write address", u_dram.log_addr[n], 4 * i);
            check_value("image write data", u_dram.log_data[n], image[i]);
            check_value("image byte enables", u_dram.log_ctrl[n], 4'hf);
        end
        check_value("load checksum", o_load_checksum, image_sum);
    endtask

    task automatic test_verify();
        int n;
        wait_init_done();
        for (int i = 0; i < IMG_WORDS; i++) begin
            n = MEM_WORDS + IMG_WORDS + i;
            check_value("readback is a read", u_dram.log_wr[n], 0);
            check_value("readback address", u_dram.log_addr[n], 4 * i);
        end
        check_value("verify checksum", o_verify_checksum, image_sum);
        check_value("load checksum kept through verify", o_load_checksum, image_sum);
        check_value("verify match", o_verify_match, 1);
    endtask

    task automatic test_user_traffic();
        logic [31:0] r, addr, wdata, rdata;
        int unsigned idx;
        for (int i = 0; i < MEM_WORDS; i++)
            shadow[i] = (i < IMG_WORDS) ? image[i] : 32'd0;  // state after maintenance
        for (int k = 0; k < N_USER_OPS; k++) begin
            r     = next_rand();
            idx   = r[29:24] % MEM_WORDS;
            addr  = (next_rand() & ~USER_MASK) | (idx * 4);  // junk in the high bits
            wdata = next_rand();
            user_access(r[31], addr, wdata, r[19:16], rdata);
            if (r[31])
                shadow[idx] = merge_bytes(shadow[idx], wdata, r[19:16]);
            else
                check_value("user read data", rdata, shadow[idx]);
        end
    endtask

    task automatic test_corruption();
        logic [31:0] flip_mask, expected;
        apply_reset();
        load_image();
        do @(negedge clk); while (!mem_rd_en);  // first readback request
        flip_mask = 32'd1 << (next_rand() >> 27);
        u_dram.mem[0] <= u_dram.mem[0] ^ flip_mask;
        expected = image_sum - image[0] + (image[0] ^ flip_mask);
        wait_init_done();
        check_value("load checksum of second image", o_load_checksum, image_sum);
        check_value("verify checksum with flipped bit", o_verify_checksum, expected);
        check_value("verify match with flipped bit", o_verify_match, 0);
    endtask

    initial begin
        i_rst        <= 1'b1;
        i_calib_done <= 1'b0;
        i_img_valid  <= 1'b0;
        i_img_data   <= '0;
        i_rd_en      <= 1'b0;
        i_wr_en      <= 1'b0;
        i_addr       <= '0;
        i_wdata      <= '0;
        i_ctrl       <= '0;
        apply_reset();

        test_reset_gate();
        test_zero_fill();
        test_image_load();
        test_verify();
        test_user_traffic();
        test_corruption();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verification/tb_dram_model.sv ====
// behavioral DRAM controller for the testbench
// busy handshake with a random hold of 2 to 5 cycles, byte-enable writes,
// and a log of every request it accepts
`timescale 1ns/1ps

module tb_dram_model #(
    parameter int unsigned MEM_SIZE  = 256,
    parameter int unsigned LOG_DEPTH = 1024
) (
    input  logic        clk,
    input  logic        i_rst,
    input  logic        i_rd_en,
    input  logic        i_wr_en,
    input  logic [31:0] i_addr,
    input  logic [31:0] i_wdata,
    input  logic [3:0]  i_ctrl,
    output logic [31:0] o_rdata,
    output logic        o_busy
);
    localparam int unsigned WORDS = MEM_SIZE / 4;

    logic [31:0] mem [WORDS];

    // request log, read back by the testbench
    logic [31:0] log_addr [LOG_DEPTH];
    logic [31:0] log_data [LOG_DEPTH];
    logic [3:0]  log_ctrl [LOG_DEPTH];
    logic        log_wr   [LOG_DEPTH];
    int          log_count;

    logic [31:0] seed = 32'hc473_588b;
    int          hold_left;
    int unsigned cur_idx;
    logic        cur_write;

    function automatic logic [31:0] next_rand(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin : cycle
        logic [31:0] rnd;
        int unsigned idx;
        if (i_rst) begin
            o_busy    <= 1'b0;
            o_rdata   <= '0;
            hold_left <= 0;
            log_count <= 0;
        end else if (o_busy) begin
            if (hold_left == 1) begin
                o_busy <= 1'b0;
                if (!cur_write)
                    o_rdata <= mem[cur_idx];  // valid as busy falls
            end
            hold_left <= hold_left - 1;
        end else if (i_rd_en || i_wr_en) begin
            rnd       = next_rand(seed);
            idx       = (i_addr >> 2) % WORDS;
            seed      <= rnd;
            o_busy    <= 1'b1;
            hold_left <= 2 + int'(rnd[31:30]);  // upper bits, better spread
            cur_idx   <= idx;
            cur_write <= i_wr_en;
            if (i_wr_en) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_ctrl[b])
                        mem[idx][8*b +: 8] <= i_wdata[8*b +: 8];
                end
            end
            if (log_count < LOG_DEPTH) begin
                log_addr[log_count] <= i_addr;
                log_data[log_count] <= i_wdata;
                log_ctrl[log_count] <= i_ctrl;
                log_wr[log_count]   <= i_wr_en;
            end
            log_count <= log_count + 1;
        end
    end

endmodule

// ==== logic/mem_maint_top.sv ====
// memory maintenance top level
// clears memory, loads and verifies a boot image, then hands the
// DRAM controller port over to the user
`timescale 1ns/1ps

module mem_maint_top #(
    parameter int unsigned MEM_SIZE       = 32'h0400_0000,
    parameter int unsigned IMAGE_SIZE     = 32'h0010_0000,
    parameter int unsigned USER_ADDR_BITS = 26
) (
    input  logic                              clk,
    input  logic                              i_rst,
    input  logic                              i_calib_done,
    // boot image stream
    input  logic                              i_img_valid,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_img_data,
    output logic                              o_img_ready,
    // user side
    input  logic                              i_rd_en,
    input  logic                              i_wr_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_addr,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_wdata,
    input  logic [mem_maint_pkg::CTRL_W-1:0]  i_ctrl,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_rdata,
    output logic                              o_busy,
    // DRAM controller side
    output logic                              o_mem_rd_en,
    output logic                              o_mem_wr_en,
    output logic [mem_maint_pkg::ADDR_W-1:0]  o_mem_addr,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_mem_wdata,
    output logic [mem_maint_pkg::CTRL_W-1:0]  o_mem_ctrl,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_mem_rdata,
    input  logic                              i_mem_busy,
    // status
    output logic                              o_init_done,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_load_checksum,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_verify_checksum,
    output logic                              o_verify_match
);
    import mem_maint_pkg::*;

    maint_stage_t      stage;
    logic              zero_run, load_run, verify_run;
    logic              zero_done, load_done, verify_done;
    logic              zero_wr_en, load_wr_en, verify_rd_en;
    logic [ADDR_W-1:0] zero_addr, load_addr, verify_addr;
    logic [DATA_W-1:0] load_wdata;

    maint_sequencer u_seq (
        .clk           (clk),
        .i_rst         (i_rst),
        .i_zero_done   (zero_done),
        .i_load_done   (load_done),
        .i_verify_done (verify_done),
        .o_stage       (stage),
        .o_zero_run    (zero_run),
        .o_load_run    (load_run),
        .o_verify_run  (verify_run),
        .o_init_done   (o_init_done)
    );

    zero_filler #(.MEM_SIZE(MEM_SIZE)) u_zero (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_run        (zero_run),
        .i_calib_done (i_calib_done),
        .i_mem_busy   (i_mem_busy),
        .o_wr_en      (zero_wr_en),
        .o_addr       (zero_addr),
        .o_done       (zero_done)
    );

    image_loader #(.IMAGE_SIZE(IMAGE_SIZE)) u_load (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_run       (load_run),
        .i_img_valid (i_img_valid),
        .i_img_data  (i_img_data),
        .o_img_ready (o_img_ready),
        .i_mem_busy  (i_mem_busy),
        .o_wr_en     (load_wr_en),
        .o_addr      (load_addr),
        .o_wdata     (load_wdata),
        .o_checksum  (o_load_checksum),
        .o_done      (load_done)
    );

    readback_verifier #(.IMAGE_SIZE(IMAGE_SIZE)) u_verify (
        .clk             (clk),
        .i_rst           (i_rst),
        .i_run           (verify_run),
        .i_mem_busy      (i_mem_busy),
        .i_mem_rdata     (i_mem_rdata),
        .i_load_checksum (o_load_checksum),
        .o_rd_en         (verify_rd_en),
        .o_addr          (verify_addr),
        .o_checksum      (o_verify_checksum),
        .o_match         (o_verify_match),
        .o_done          (verify_done)
    );

    mem_port_mux #(.USER_ADDR_BITS(USER_ADDR_BITS)) u_mux (
        .i_stage        (stage),
        .i_zero_wr_en   (zero_wr_en),
        .i_zero_addr    (zero_addr),
        .i_load_wr_en   (load_wr_en),
        .i_load_addr    (load_addr),
        .i_load_wdata   (load_wdata),
        .i_verify_rd_en (verify_rd_en),
        .i_verify_addr  (verify_addr),
        .i_rd_en        (i_rd_en),
        .i_wr_en        (i_wr_en),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_ctrl         (i_ctrl),
        .o_rdata        (o_rdata),
        .o_busy         (o_busy),
        .o_mem_rd_en    (o_mem_rd_en),
        .o_mem_wr_en    (o_mem_wr_en),
        .o_mem_addr     (o_mem_addr),
        .o_mem_wdata    (o_mem_wdata),
        .o_mem_ctrl     (o_mem_ctrl),
        .i_mem_rdata    (i_mem_rdata),
        .i_mem_busy     (i_mem_busy)
    );

endmodule

// ==== logic/mem_port_mux.sv ====
// controller port select
// the active maintenance engine owns the port until ready, then the user
`timescale 1ns/1ps

module mem_port_mux #(
    parameter int unsigned USER_ADDR_BITS = 26
) (
    input  mem_maint_pkg::maint_stage_t       i_stage,
    input  logic                              i_zero_wr_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_zero_addr,
    input  logic                              i_load_wr_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_load_addr,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_load_wdata,
    input  logic                              i_verify_rd_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_verify_addr,
    input  logic                              i_rd_en,
    input  logic                              i_wr_en,
    input  logic [mem_maint_pkg::ADDR_W-1:0]  i_addr,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_wdata,
    input  logic [mem_maint_pkg::CTRL_W-1:0]  i_ctrl,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_rdata,
    output logic                              o_busy,
    output logic                              o_mem_rd_en,
    output logic                              o_mem_wr_en,
    output logic [mem_maint_pkg::ADDR_W-1:0]  o_mem_addr,
    output logic [mem_maint_pkg::DATA_W-1:0]  o_mem_wdata,
    output logic [mem_maint_pkg::CTRL_W-1:0]  o_mem_ctrl,
    input  logic [mem_maint_pkg::DATA_W-1:0]  i_mem_rdata,
    input  logic                              i_mem_busy
);
    import mem_maint_pkg::*;

    // keeps user addresses inside the physical memory
    localparam logic [ADDR_W-1:0] USER_MASK = ADDR_W'((64'd1 << USER_ADDR_BITS) - 64'd1);

    always_comb begin
        o_mem_rd_en = 1'b0;
        o_mem_wr_en = 1'b0;
        o_mem_addr  = '0;
        o_mem_wdata = '0;  // zero fill relies on this
        o_mem_ctrl  = CTRL_ALL;
        case (i_stage)
            STG_ZERO: begin
                o_mem_wr_en = i_zero_wr_en;
                o_mem_addr  = i_zero_addr;
            end
            STG_LOAD: begin
                o_mem_wr_en = i_load_wr_en;
                o_mem_addr  = i_load_addr;
                o_mem_wdata = i_load_wdata;
            end
            STG_VERIFY: begin
                o_mem_rd_en = i_verify_rd_en;
                o_mem_addr  = i_verify_addr;
            end
            STG_READY: begin
                o_mem_rd_en = i_rd_en;
                o_mem_wr_en = i_wr_en;
                o_mem_addr  = i_addr & USER_MASK;
                o_mem_wdata = i_wdata;
                o_mem_ctrl  = i_ctrl;
            end
            default: ;  // start stage drives nothing
        endcase
    end

    assign o_rdata = i_mem_rdata;
    assign o_busy  = (i_stage == STG_READY) ? i_mem_busy : 1'b1;  // blocked until ready

endmodule

// ==== logic/readback_verifier.sv ====
// image readback verifier
// reads the image region back, sums the returned words and compares
// the result with the load checksum
`timescale 1ns/1ps

module readback_verifier #(
    parameter int unsigned IMAGE_SIZE = 128
) (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_run,
    input  logic                             i_mem_busy,
    input  logic [mem_maint_pkg::DATA_W-1:0] i_mem_rdata,
    input  logic [mem_maint_pkg::DATA_W-1:0] i_load_checksum,
    output logic                             o_rd_en,
    output logic [mem_maint_pkg::ADDR_W-1:0] o_addr,
    output logic [mem_maint_pkg::DATA_W-1:0] o_checksum,
    output logic                             o_match,
    output logic                             o_done
);
    import mem_maint_pkg::*;

    localparam logic [ADDR_W-1:0] END_ADDR = ADDR_W'(IMAGE_SIZE);

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_WAIT_HI = 2'd1;  // read posted
    localparam logic [1:0] S_WAIT_LO = 2'd2;  // data arrives on busy fall

    logic [1:0] state;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            o_rd_en    <= 1'b0;
            o_addr     <= '0;
            o_checksum <= '0;
            o_match    <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_run && !o_done) begin
                        if (o_addr >= END_ADDR) begin
                            // whole region read back
                            o_done  <= 1'b1;
                            o_match <= (o_checksum == i_load_checksum);
                        end else if (!i_mem_busy) begin
                            o_rd_en <= 1'b1;
                            state   <= S_WAIT_HI;
                        end
                    end
                end
                S_WAIT_HI: begin
                    if (i_mem_busy) begin
                        o_rd_en <= 1'b0;
                        state   <= S_WAIT_LO;
                    end
                end
                S_WAIT_LO: begin
                    if (!i_mem_busy) begin
                        o_checksum <= o_checksum + i_mem_rdata;
                        o_addr     <= o_addr + BYTES_PER_WORD;
                        state      <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

// ==== logic/image_loader.sv ====
// boot image loader
// takes words from the image stream, writes them from address 0 upward
// and keeps a running sum of all loaded words
`timescale 1ns/1ps

module image_loader #(
    parameter int unsigned IMAGE_SIZE = 128
) (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_run,
    input  logic                             i_img_valid,
    input  logic [mem_maint_pkg::DATA_W-1:0] i_img_data,
    output logic                             o_img_ready,
    input  logic                             i_mem_busy,
    output logic                             o_wr_en,
    output logic [mem_maint_pkg::ADDR_W-1:0] o_addr,
    output logic [mem_maint_pkg::DATA_W-1:0] o_wdata,
    output logic [mem_maint_pkg::DATA_W-1:0] o_checksum,
    output logic                             o_done
);
    import mem_maint_pkg::*;

    localparam logic [ADDR_W-1:0] END_ADDR = ADDR_W'(IMAGE_SIZE);

    localparam logic [1:0] S_IDLE    = 2'd0;  // ready for a stream word
    localparam logic [1:0] S_WAIT_HI = 2'd1;  // write posted, waiting for busy
    localparam logic [1:0] S_WAIT_LO = 2'd2;  // write in progress

    logic [1:0] state;
    logic       accept;

    assign o_img_ready = i_run && (state == S_IDLE) && !i_mem_busy && (o_addr < END_ADDR);
    assign accept      = o_img_ready && i_img_valid;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            o_wr_en    <= 1'b0;
            o_addr     <= '0;
            o_checksum <= '0;
            o_done     <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        o_wr_en    <= 1'b1;
                        o_checksum <= o_checksum + i_img_data;  // wraps mod 2^32
                        state      <= S_WAIT_HI;
                    end
                end
                S_WAIT_HI: begin
                    if (i_mem_busy) begin
                        o_wr_en <= 1'b0;
                        state   <= S_WAIT_LO;
                    end
                end
                S_WAIT_LO: begin
                    if (!i_mem_busy) begin  // write complete
                        o_addr <= o_addr + BYTES_PER_WORD;
                        state  <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase

            if (o_addr >= END_ADDR)
                o_done <= 1'b1;
        end
    end

    // held for the controller until the write completes
    always_ff @(posedge clk) begin
        if (accept)
            o_wdata <= i_img_data;
    end

endmodule

// ==== logic/zero_filler.sv ====
// zero fill engine
// writes zero to every word from address 0 up to MEM_SIZE
`timescale 1ns/1ps

module zero_filler #(
    parameter int unsigned MEM_SIZE = 256
) (
    input  logic                             clk,
    input  logic                             i_rst,
    input  logic                             i_run,
    input  logic                             i_calib_done,
    input  logic                             i_mem_busy,
    output logic                             o_wr_en,
    output logic [mem_maint_pkg::ADDR_W-1:0] o_addr,
    output logic                             o_done
);
    import mem_maint_pkg::*;

    localparam logic [ADDR_W-1:0] END_ADDR = ADDR_W'(MEM_SIZE);

    logic more_words;

    assign more_words = (o_addr < END_ADDR);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
            o_addr  <= '0;
            o_done  <= 1'b0;
        end else begin
            if (o_wr_en) begin
                if (i_mem_busy) begin  // controller took it
                    o_wr_en <= 1'b0;
                    o_addr  <= o_addr + BYTES_PER_WORD;
                end
            end else if (i_run && i_calib_done && !i_mem_busy && more_words) begin
                o_wr_en <= 1'b1;
            end

            // last write must be finished too
            if (i_run && !more_words && !o_wr_en && !i_mem_busy)
                o_done <= 1'b1;
        end
    end

endmodule

// ==== logic/maint_sequencer.sv ====
// maintenance sequencer
// steps start -> zero fill -> image load -> verify -> ready
`timescale 1ns/1ps

module maint_sequencer (
    input  logic                        clk,
    input  logic                        i_rst,
    input  logic                        i_zero_done,
    input  logic                        i_load_done,
    input  logic                        i_verify_done,
    output mem_maint_pkg::maint_stage_t o_stage,
    output logic                        o_zero_run,
    output logic                        o_load_run,
    output logic                        o_verify_run,
    output logic                        o_init_done
);
    import mem_maint_pkg::*;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_stage <= STG_START;
        end else begin
            case (o_stage)
                STG_START: o_stage <= STG_ZERO;  // one cycle after reset
                STG_ZERO: begin
                    if (i_zero_done)
                        o_stage <= STG_LOAD;
                end
                STG_LOAD: begin
                    if (i_load_done)
                        o_stage <= STG_VERIFY;
                end
                STG_VERIFY: begin
                    if (i_verify_done)
                        o_stage <= STG_READY;
                end
                STG_READY: o_stage <= STG_READY;  // stays until next reset
                default:   o_stage <= STG_START;
            endcase
        end
    end

    // one run strobe per engine
    assign o_zero_run   = (o_stage == STG_ZERO);
    assign o_load_run   = (o_stage == STG_LOAD);
    assign o_verify_run = (o_stage == STG_VERIFY);

    // user port opens with the ready stage
    assign o_init_done  = (o_stage == STG_READY);

endmodule

// ==== logic/mem_maint_pkg.sv ====
// memory maintenance shared definitions
// bus widths, word step and the maintenance stage encoding
package mem_maint_pkg;

    // memory port widths
    localparam int unsigned ADDR_W = 32;  // byte address
    localparam int unsigned DATA_W = 32;
    localparam int unsigned CTRL_W = 4;   // one enable per byte lane

    // address step between consecutive words
    localparam logic [ADDR_W-1:0] BYTES_PER_WORD = ADDR_W'(4);

    // maintenance writes always cover the full word
    localparam logic [CTRL_W-1:0] CTRL_ALL = '1;

    // stages of the maintenance sequence
    typedef enum logic [2:0] {
        STG_START  = 3'd0,  // just out of reset
        STG_ZERO   = 3'd1,  // clearing the whole memory
        STG_LOAD   = 3'd2,  // copying the boot image in
        STG_VERIFY = 3'd3,  // reading the image back
        STG_READY  = 3'd4   // user owns the port
    } maint_stage_t;

endpackage
